// File: include/engine_defs.svh
`ifndef ENGINE_DEFS_SVH
`define ENGINE_DEFS_SVH

// ---------------------------------------------------------------------------
// field geometry

`define NUM_SLOTS      8          // unit slots per side
`define ENEMY_SPAWN_X  10'd10
`define ARMY_SPAWN_X   10'd570
`define TOWER_E_X      10'd70
`define TOWER_A_X      10'd570

// ---------------------------------------------------------------------------
// tower, fire and economy

`define TOWER_HP_INIT  12'd4000
`define FIRE_LINE      10'd250    // enemies past this x get shot
`define FIRE_DAMAGE    12'd300
`define CHARGE_MAX     7'd127
`define SCHED_LEN      16         // entries in the enemy schedule
`define PURSE_TOP      3'd7

`endif

// File: source/unit_pkg.sv
`include "engine_defs.svh"

package unit_pkg;

    typedef logic [9:0]  x_t;
    typedef logic [11:0] hp_t;
    typedef logic [3:0]  cd_t;

    typedef enum logic [1:0] {
        killer_bird,
        white_bear,
        metal_duck,
        black_bear
    } unit_kind_e;

    typedef struct packed {
        logic       alive;
        unit_kind_e kind;
        x_t         x;
        hp_t        hp;
        cd_t        cd;     // attack period counter
    } unit_t;

    typedef struct packed {
        hp_t         hp;
        logic [8:0]  damage;
        logic [4:0]  speed;
        logic [7:0]  range;
        cd_t         period;
        logic [14:0] cost;
    } unit_stats_t;

    typedef struct packed {
        logic [11:0] at;    // game time of the spawn
        unit_kind_e  kind;
    } sched_t;

    // same table for both sides
    function automatic unit_stats_t unit_stats(input unit_kind_e kind);
        unit_stats_t s;
        case (kind)
            killer_bird: s = '{12'd200, 9'd40, 5'd6, 8'd20, 4'd3, 15'd50};
            white_bear:  s = '{12'd600, 9'd60, 5'd3, 8'd15, 4'd5, 15'd150};
            metal_duck:  s = '{12'd400, 9'd120, 5'd4, 8'd60, 4'd7, 15'd250};
            default:     s = '{12'd1500, 9'd200, 5'd2, 8'd10, 4'd9, 15'd400};
        endcase
        return s;
    endfunction

    function automatic sched_t enemy_schedule(input logic [$clog2(`SCHED_LEN)-1:0] idx);
        sched_t e;
        case (idx)
            4'd0:    e = '{12'd2, killer_bird};
            4'd1:    e = '{12'd10, killer_bird};
            4'd2:    e = '{12'd20, white_bear};
            4'd3:    e = '{12'd30, killer_bird};
            4'd4:    e = '{12'd40, metal_duck};
            4'd5:    e = '{12'd55, white_bear};
            4'd6:    e = '{12'd70, killer_bird};
            4'd7:    e = '{12'd85, black_bear};
            4'd8:    e = '{12'd100, metal_duck};
            4'd9:    e = '{12'd120, white_bear};
            4'd10:   e = '{12'd140, killer_bird};
            4'd11:   e = '{12'd160, black_bear};
            4'd12:   e = '{12'd180, metal_duck};
            4'd13:   e = '{12'd200, white_bear};
            4'd14:   e = '{12'd230, black_bear};
            default: e = '{12'd260, black_bear};
        endcase
        return e;
    endfunction

endpackage

// File: source/game_pkg.sv
package game_pkg;

    typedef logic [14:0] money_t;
    typedef logic [2:0]  level_t;
    typedef logic [11:0] time_t;
    typedef logic [6:0]  charge_t;

    typedef enum logic [2:0] {
        idle,
        spawn_enemy,
        spawn_army,
        update,
        fire,
        econ,
        done
    } phase_e;

    typedef struct packed {
        logic                 buy_valid;
        unit_pkg::unit_kind_e buy_kind;
        logic                 upgrade;
        logic                 fire;
    } command_t;

    typedef struct packed {
        money_t         money;
        level_t         level;
        charge_t        charge;
        unit_pkg::hp_t  tower_hp_e;
        unit_pkg::hp_t  tower_hp_a;
        time_t          game_time;
        logic [3:0]     army_count;
        logic [3:0]     enemy_count;
    } status_t;

    // ------------------------------------------------------------------------
    // purse tables

    function automatic money_t purse_income(input level_t level);
        case (level)
            3'd0:       return 15'd1;
            3'd1, 3'd2: return 15'd2;
            3'd3:       return 15'd3;
            3'd4:       return 15'd4;
            default:    return 15'd5;
        endcase
    endfunction

    function automatic money_t purse_cap(input level_t level);
        return 15'd500 * (15'(level) + 15'd1);
    endfunction

    function automatic money_t upgrade_cost(input level_t level);
        return 15'd100 * (15'(level) + 15'd1);
    endfunction

endpackage

// File: source/command_latch.sv
`timescale 1ns/1ps

module command_latch (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 init,
    input  logic                 buy,
    input  unit_pkg::unit_kind_e buy_kind,
    input  logic                 upgrade,
    input  logic                 fire_cmd,
    input  game_pkg::phase_e     phase,
    output game_pkg::command_t   pending
);

    // a click in the consuming cycle keeps the request for the next frame
    always_ff @(posedge clk_25MHz) begin
        if (rst || init) begin
            pending <= '0;
        end else begin
            if (buy) begin
                pending.buy_valid <= 1'b1;
                pending.buy_kind  <= buy_kind;  // later click overwrites
            end else if (phase == game_pkg::spawn_army) begin
                pending.buy_valid <= 1'b0;
            end

            if (upgrade)
                pending.upgrade <= 1'b1;
            else if (phase == game_pkg::econ)
                pending.upgrade <= 1'b0;

            if (fire_cmd)
                pending.fire <= 1'b1;
            else if (phase == game_pkg::fire)
                pending.fire <= 1'b0;
        end
    end

endmodule

// File: source/tick_sequencer.sv
`timescale 1ns/1ps
`include "engine_defs.svh"

module tick_sequencer (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  logic             start,
    input  logic             frame_tick,
    input  logic             game_over,
    output game_pkg::phase_e phase,
    output logic [2:0]       slot,
    output game_pkg::time_t  game_time,
    output logic             init
);

    assign init = start;    // restart reaches every block in the same edge

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            phase     <= game_pkg::idle;
            slot      <= 3'd0;
            game_time <= 12'd0;
        end else begin
            case (phase)
                game_pkg::idle: begin
                    if (frame_tick && !game_over)
                        phase <= game_pkg::spawn_enemy;
                end
                game_pkg::spawn_enemy: phase <= game_pkg::spawn_army;
                game_pkg::spawn_army:  phase <= game_pkg::update;
                game_pkg::update: begin
                    slot <= slot + 3'd1;    // wraps to 0 after the last slot
                    if (slot == 3'(`NUM_SLOTS - 1))
                        phase <= game_pkg::fire;
                end
                game_pkg::fire: phase <= game_pkg::econ;
                game_pkg::econ: begin
                    phase     <= game_pkg::done;
                    game_time <= game_time + 12'd1;
                end
                default: phase <= game_pkg::idle;
            endcase
        end
    end

    // slot walks only during the update sweep
    assert property (@(posedge clk_25MHz) disable iff (rst)
        $changed(slot) |-> $past(phase) == game_pkg::update);

endmodule

// File: source/battle_field.sv
`timescale 1ns/1ps
`include "engine_defs.svh"

module battle_field (
    input  logic               clk_25MHz,
    input  logic               rst,
    input  logic               init,
    input  game_pkg::phase_e   phase,
    input  logic [2:0]         slot,
    input  game_pkg::time_t    game_time,
    input  game_pkg::command_t pending,
    input  game_pkg::money_t   money,
    input  game_pkg::charge_t  charge,
    output logic               buy_ok,
    output logic               fired,
    output unit_pkg::hp_t      tower_hp_e,
    output unit_pkg::hp_t      tower_hp_a,
    output logic [3:0]         army_count,
    output logic [3:0]         enemy_count
);

    unit_pkg::unit_t       enemy [`NUM_SLOTS];
    unit_pkg::unit_t       army [`NUM_SLOTS];
    logic [4:0]            sched_ptr;
    unit_pkg::sched_t      sched;
    unit_pkg::unit_stats_t e_st;
    unit_pkg::unit_stats_t a_st;
    unit_pkg::unit_stats_t buy_st;
    logic [2:0]            e_idx;
    logic [2:0]            a_idx;
    logic                  e_free;
    logic                  a_free;
    logic                  sched_go;
    logic                  e_reach;
    logic                  a_reach;

    function automatic unit_pkg::unit_t new_unit(input unit_pkg::unit_kind_e k,
                                                 input unit_pkg::x_t x0);
        return '{1'b1, k, x0, unit_pkg::unit_stats(k).hp, 4'd0};
    endfunction

    function automatic unit_pkg::hp_t hit(input unit_pkg::hp_t hp, input logic [8:0] dmg);
        return (12'(dmg) >= hp) ? 12'd0 : hp - 12'(dmg);
    endfunction

    // lowest free slot per side and live counts
    always_comb begin
        e_free      = 1'b0;
        a_free      = 1'b0;
        e_idx       = 3'd0;
        a_idx       = 3'd0;
        army_count  = 4'd0;
        enemy_count = 4'd0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (!enemy[i].alive) begin
                e_free = 1'b1;
                e_idx  = 3'(i);
            end
            if (!army[i].alive) begin
                a_free = 1'b1;
                a_idx  = 3'(i);
            end
            enemy_count = enemy_count + 4'(enemy[i].alive);
            army_count  = army_count + 4'(army[i].alive);
        end
    end

    assign sched    = unit_pkg::enemy_schedule(sched_ptr[3:0]);
    assign sched_go = sched_ptr < 5'(`SCHED_LEN) && sched.at <= game_time && e_free;
    assign buy_st   = unit_pkg::unit_stats(pending.buy_kind);
    assign buy_ok   = phase == game_pkg::spawn_army && pending.buy_valid && a_free
                      && money >= buy_st.cost;
    assign fired    = phase == game_pkg::fire && pending.fire && charge == `CHARGE_MAX;

    assign e_st    = unit_pkg::unit_stats(enemy[slot].kind);
    assign a_st    = unit_pkg::unit_stats(army[slot].kind);
    assign e_reach = 11'(enemy[slot].x) + 11'(e_st.range) >= 11'(`TOWER_A_X);
    assign a_reach = 11'(`TOWER_E_X) + 11'(a_st.range) >= 11'(army[slot].x);

    always_ff @(posedge clk_25MHz) begin
        if (rst || init) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                enemy[i].alive <= 1'b0;
                army[i].alive  <= 1'b0;
            end
            sched_ptr  <= 5'd0;
            tower_hp_e <= `TOWER_HP_INIT;
            tower_hp_a <= `TOWER_HP_INIT;
        end else begin
            case (phase)
                game_pkg::spawn_enemy: begin
                    if (sched_go) begin
                        enemy[e_idx] <= new_unit(sched.kind, `ENEMY_SPAWN_X);
                        sched_ptr    <= sched_ptr + 5'd1;
                    end
                end
                game_pkg::spawn_army: begin
                    if (buy_ok)
                        army[a_idx] <= new_unit(pending.buy_kind, `ARMY_SPAWN_X);
                end
                game_pkg::update: begin
                    // enemies walk right toward the player's tower
                    if (enemy[slot].alive) begin
                        if (!e_reach) begin
                            enemy[slot].x <= enemy[slot].x + 10'(e_st.speed);
                        end else if (enemy[slot].cd == e_st.period) begin
                            enemy[slot].cd <= 4'd0;
                            tower_hp_a     <= hit(tower_hp_a, e_st.damage);
                        end else begin
                            enemy[slot].cd <= enemy[slot].cd + 4'd1;
                        end
                    end
                    if (army[slot].alive) begin
                        if (!a_reach) begin
                            army[slot].x <= army[slot].x - 10'(a_st.speed);
                        end else if (army[slot].cd == a_st.period) begin
                            army[slot].cd <= 4'd0;
                            tower_hp_e    <= hit(tower_hp_e, a_st.damage);
                        end else begin
                            army[slot].cd <= army[slot].cd + 4'd1;
                        end
                    end
                end
                game_pkg::fire: begin
                    for (int i = 0; i < `NUM_SLOTS; i++) begin
                        if (fired && enemy[i].alive && enemy[i].x > `FIRE_LINE) begin
                            if (enemy[i].hp <= `FIRE_DAMAGE)
                                enemy[i].alive <= 1'b0;
                            else
                                enemy[i].hp <= enemy[i].hp - `FIRE_DAMAGE;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // towers only heal through a restart
    assert property (@(posedge clk_25MHz) disable iff (rst)
        !$past(init) && !$past(rst) |->
            tower_hp_e <= $past(tower_hp_e) && tower_hp_a <= $past(tower_hp_a));

    // accepted buy lands in a slot on the next edge
    assert property (@(posedge clk_25MHz) disable iff (rst || init)
        buy_ok |=> $past(phase) == game_pkg::spawn_army
                   && army_count == $past(army_count) + 4'd1);

endmodule

// File: source/treasury.sv
`timescale 1ns/1ps
`include "engine_defs.svh"

module treasury (
    input  logic               clk_25MHz,
    input  logic               rst,
    input  logic               init,
    input  game_pkg::phase_e   phase,
    input  game_pkg::command_t pending,
    input  logic               buy_ok,
    input  logic               fired,
    output game_pkg::money_t   money,
    output game_pkg::level_t   level,
    output game_pkg::charge_t  charge
);

    game_pkg::money_t up_cost;
    game_pkg::money_t after_up;
    game_pkg::money_t cap;
    game_pkg::money_t buy_cost;
    game_pkg::level_t lvl_next;
    logic [15:0]      sum;      // one spare bit for the cap check
    logic             up_ok;

    always_comb begin
        up_cost  = game_pkg::upgrade_cost(level);
        up_ok    = pending.upgrade && level < `PURSE_TOP && money >= up_cost;
        lvl_next = up_ok ? level + 3'd1 : level;
        after_up = up_ok ? money - up_cost : money;
        cap      = game_pkg::purse_cap(lvl_next);
        sum      = {1'b0, after_up} + {1'b0, game_pkg::purse_income(lvl_next)};
    end

    assign buy_cost = unit_pkg::unit_stats(pending.buy_kind).cost;

    always_ff @(posedge clk_25MHz) begin
        if (rst || init) begin
            money  <= 15'd0;
            level  <= 3'd0;
            charge <= 7'd0;
        end else begin
            if (buy_ok)
                money <= money - buy_cost;
            if (fired)
                charge <= 7'd0;
            if (phase == game_pkg::econ) begin
                level <= lvl_next;
                money <= (sum > {1'b0, cap}) ? cap : sum[14:0];
                if (charge < `CHARGE_MAX)
                    charge <= charge + 7'd1;
            end
        end
    end

    assert property (@(posedge clk_25MHz) disable iff (rst)
        $past(phase) == game_pkg::econ |-> money <= game_pkg::purse_cap(level));

endmodule

// File: source/status_report.sv
`timescale 1ns/1ps

module status_report (
    input  logic              clk_25MHz,
    input  logic              rst,
    input  logic              init,
    input  game_pkg::phase_e  phase,
    input  game_pkg::money_t  money,
    input  game_pkg::level_t  level,
    input  game_pkg::charge_t charge,
    input  unit_pkg::hp_t     tower_hp_e,
    input  unit_pkg::hp_t     tower_hp_a,
    input  game_pkg::time_t   game_time,
    input  logic [3:0]        army_count,
    input  logic [3:0]        enemy_count,
    output game_pkg::status_t status,
    output logic              win,
    output logic              lose,
    output logic              tick_done,
    output logic              game_over
);

    always_ff @(posedge clk_25MHz) begin
        if (rst || init) begin
            status    <= '0;
            win       <= 1'b0;
            lose      <= 1'b0;
            tick_done <= 1'b0;
        end else begin
            tick_done <= (phase == game_pkg::done);
            if (phase == game_pkg::done) begin
                status <= '{money, level, charge, tower_hp_e, tower_hp_a,
                            game_time, army_count, enemy_count};
                if (tower_hp_a == 12'd0)
                    lose <= 1'b1;   // own tower first
                else if (tower_hp_e == 12'd0)
                    win <= 1'b1;
            end
        end
    end

    assign game_over = win | lose;

endmodule

// File: source/game_engine.sv
`timescale 1ns/1ps

module game_engine (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 frame_tick,
    input  logic                 buy,
    input  unit_pkg::unit_kind_e buy_kind,
    input  logic                 upgrade,
    input  logic                 fire_cmd,
    output game_pkg::status_t    status,
    output logic                 win,
    output logic                 lose,
    output logic                 tick_done
);

    game_pkg::phase_e   phase;
    game_pkg::command_t pending;
    game_pkg::time_t    game_time;
    game_pkg::money_t   money;
    game_pkg::level_t   level;
    game_pkg::charge_t  charge;
    unit_pkg::hp_t      tower_hp_e;
    unit_pkg::hp_t      tower_hp_a;
    logic [2:0]         slot;
    logic [3:0]         army_count;
    logic [3:0]         enemy_count;
    logic               init;
    logic               buy_ok;
    logic               fired;
    logic               game_over;

    // ------------------------------------------------------------------------
    // input side

    command_latch command_latch_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .init(init),
        .buy(buy), .buy_kind(buy_kind), .upgrade(upgrade), .fire_cmd(fire_cmd),
        .phase(phase), .pending(pending)
    );

    // ------------------------------------------------------------------------
    // per-frame processing

    tick_sequencer tick_sequencer_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start), .frame_tick(frame_tick),
        .game_over(game_over), .phase(phase), .slot(slot), .game_time(game_time),
        .init(init)
    );

    battle_field battle_field_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .init(init), .phase(phase), .slot(slot),
        .game_time(game_time), .pending(pending), .money(money), .charge(charge),
        .buy_ok(buy_ok), .fired(fired), .tower_hp_e(tower_hp_e),
        .tower_hp_a(tower_hp_a), .army_count(army_count), .enemy_count(enemy_count)
    );

    treasury treasury_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .init(init), .phase(phase),
        .pending(pending), .buy_ok(buy_ok), .fired(fired),
        .money(money), .level(level), .charge(charge)
    );

    // ------------------------------------------------------------------------
    // output side

    status_report status_report_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .init(init), .phase(phase),
        .money(money), .level(level), .charge(charge),
        .tower_hp_e(tower_hp_e), .tower_hp_a(tower_hp_a), .game_time(game_time),
        .army_count(army_count), .enemy_count(enemy_count), .status(status),
        .win(win), .lose(lose), .tick_done(tick_done), .game_over(game_over)
    );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_25MHz
);

    initial clk_25MHz = 1'b0;

    always #(PERIOD_NS / 2) clk_25MHz = ~clk_25MHz;

endmodule

// File: tb/tb_game_engine.sv
`timescale 1ns/1ps
`include "engine_defs.svh"

module tb_game_engine;

    localparam int TICK_TIMEOUT = 40;
    localparam int TICK_LATENCY = 13;   // edges from frame_tick capture to tick_done
    localparam int MAX_FRAMES   = 800;
    localparam int QUIET_CYCLES = 20;
    localparam int SCHED_AT [16] = '{2, 10, 20, 30, 40, 55, 70, 85,
                                     100, 120, 140, 160, 180, 200, 230, 260};

    logic                 clk_25MHz;
    logic                 rst;
    logic                 start;
    logic                 frame_tick;
    logic                 buy;
    unit_pkg::unit_kind_e buy_kind;
    logic                 upgrade;
    logic                 fire_cmd;
    game_pkg::status_t    status;
    logic                 win;
    logic                 lose;
    logic                 tick_done;

    // reference model state
    unit_pkg::unit_t m_enemy [`NUM_SLOTS];
    unit_pkg::unit_t m_army [`NUM_SLOTS];
    int              m_ptr;
    int              m_money;
    int              m_level;
    int              m_charge;
    int              m_hp_e;
    int              m_hp_a;
    int              m_time;
    bit              m_win;
    bit              m_lose;

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          timeouts;
    int          frames;
    bit          ok;

    clock_gen clock_gen_inst (.clk_25MHz(clk_25MHz));

    game_engine game_engine_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start), .frame_tick(frame_tick),
        .buy(buy), .buy_kind(buy_kind), .upgrade(upgrade), .fire_cmd(fire_cmd),
        .status(status), .win(win), .lose(lose), .tick_done(tick_done)
    );

    // ------------------------------------------------------------------------
    // game rules

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // hp, damage, speed, range, period, cost
    function automatic unit_pkg::unit_stats_t stats_for(input unit_pkg::unit_kind_e kind);
        case (kind)
            unit_pkg::killer_bird: return '{12'd200, 9'd40, 5'd6, 8'd20, 4'd3, 15'd50};
            unit_pkg::white_bear:  return '{12'd600, 9'd60, 5'd3, 8'd15, 4'd5, 15'd150};
            unit_pkg::metal_duck:  return '{12'd400, 9'd120, 5'd4, 8'd60, 4'd7, 15'd250};
            default:               return '{12'd1500, 9'd200, 5'd2, 8'd10, 4'd9, 15'd400};
        endcase
    endfunction

    function automatic unit_pkg::unit_kind_e sched_kind(input int idx);
        case (idx)
            0, 1, 3, 6, 10: return unit_pkg::killer_bird;
            2, 5, 9, 13:    return unit_pkg::white_bear;
            4, 8, 12:       return unit_pkg::metal_duck;
            default:        return unit_pkg::black_bear;
        endcase
    endfunction

    function automatic int income_at(input int lvl);
        case (lvl)
            0:       return 1;
            1, 2:    return 2;
            3:       return 3;
            4:       return 4;
            default: return 5;
        endcase
    endfunction

    function automatic int apply_hit(input int hp, input int dmg);
        return (dmg >= hp) ? 0 : hp - dmg;
    endfunction

    // lowest dead slot of one side or -1 when full
    function automatic int free_slot(input bit enemy_side);
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (enemy_side ? !m_enemy[i].alive : !m_army[i].alive)
                return i;
        end
        return -1;
    endfunction

    function automatic int count_alive(input bit enemy_side);
        int n;
        n = 0;
        for (int i = 0; i < `NUM_SLOTS; i++)
            n += enemy_side ? int'(m_enemy[i].alive) : int'(m_army[i].alive);
        return n;
    endfunction

    task automatic model_init();
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            m_enemy[i] = '0;
            m_army[i]  = '0;
        end
        m_ptr    = 0;
        m_money  = 0;
        m_level  = 0;
        m_charge = 0;
        m_hp_e   = int'(`TOWER_HP_INIT);
        m_hp_a   = int'(`TOWER_HP_INIT);
        m_time   = 0;
        m_win    = 1'b0;
        m_lose   = 1'b0;
    endtask

    // one whole frame in phase order
    task automatic model_tick(input bit do_buy, input unit_pkg::unit_kind_e kind,
                              input bit do_up, input bit do_fire);
        unit_pkg::unit_stats_t st;
        int                    idx;
        idx = free_slot(1'b1);
        if (m_ptr < `SCHED_LEN && idx >= 0 && SCHED_AT[m_ptr] <= m_time) begin
            st           = stats_for(sched_kind(m_ptr));
            m_enemy[idx] = '{1'b1, sched_kind(m_ptr), `ENEMY_SPAWN_X, st.hp, 4'd0};
            m_ptr++;
        end
        st  = stats_for(kind);
        idx = free_slot(1'b0);
        if (do_buy && idx >= 0 && m_money >= int'(st.cost)) begin
            m_army[idx] = '{1'b1, kind, `ARMY_SPAWN_X, st.hp, 4'd0};
            m_money    -= int'(st.cost);
        end
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (m_enemy[i].alive) begin
                st = stats_for(m_enemy[i].kind);
                if (11'(m_enemy[i].x) + 11'(st.range) < 11'(`TOWER_A_X)) begin
                    m_enemy[i].x = m_enemy[i].x + 10'(st.speed);
                end else if (m_enemy[i].cd == st.period) begin
                    m_enemy[i].cd = 4'd0;
                    m_hp_a        = apply_hit(m_hp_a, int'(st.damage));
                end else begin
                    m_enemy[i].cd = m_enemy[i].cd + 4'd1;
                end
            end
            if (m_army[i].alive) begin
                st = stats_for(m_army[i].kind);
                if (11'(`TOWER_E_X) + 11'(st.range) < 11'(m_army[i].x)) begin
                    m_army[i].x = m_army[i].x - 10'(st.speed);
                end else if (m_army[i].cd == st.period) begin
                    m_army[i].cd = 4'd0;
                    m_hp_e       = apply_hit(m_hp_e, int'(st.damage));
                end else begin
                    m_army[i].cd = m_army[i].cd + 4'd1;
                end
            end
        end
        if (do_fire && m_charge == int'(`CHARGE_MAX)) begin
            m_charge = 0;
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                if (m_enemy[i].alive && m_enemy[i].x > `FIRE_LINE) begin
                    if (m_enemy[i].hp <= `FIRE_DAMAGE)
                        m_enemy[i].alive = 1'b0;
                    else
                        m_enemy[i].hp = m_enemy[i].hp - `FIRE_DAMAGE;
                end
            end
        end
        // econ does the upgrade before income at the new level
        if (do_up && m_level < int'(`PURSE_TOP) && m_money >= 100 * (m_level + 1)) begin
            m_money -= 100 * (m_level + 1);
            m_level++;
        end
        m_money += income_at(m_level);
        if (m_money > 500 * (m_level + 1))
            m_money = 500 * (m_level + 1);
        if (m_charge < int'(`CHARGE_MAX))
            m_charge++;
        m_time++;
        if (m_hp_a == 0)
            m_lose = 1'b1;      // own tower first
        else if (m_hp_e == 0)
            m_win = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // checks and stimulus

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_status(input int latency);
        check_value("tick latency", latency, TICK_LATENCY);
        check_value("money", 32'(status.money), m_money);
        check_value("level", 32'(status.level), m_level);
        check_value("charge", 32'(status.charge), m_charge);
        check_value("enemy tower hp", 32'(status.tower_hp_e), m_hp_e);
        check_value("player tower hp", 32'(status.tower_hp_a), m_hp_a);
        check_value("game time", 32'(status.game_time), m_time);
        check_value("army count", 32'(status.army_count), count_alive(1'b0));
        check_value("enemy count", 32'(status.enemy_count), count_alive(1'b1));
        check_value("win", 32'(win), 32'(m_win));
        check_value("lose", 32'(lose), 32'(m_lose));
    endtask

    task automatic wait_tick_done(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TICK_TIMEOUT) begin
            @(negedge clk_25MHz);
            cycles++;
            if (tick_done)
                seen = 1'b1;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no tick_done within %0d cycles at %0t ns", TICK_TIMEOUT, $time);
        end
    endtask

    task automatic run_frame(input bit do_buy, input unit_pkg::unit_kind_e kind,
                             input bit do_up, input bit do_fire, output bit seen);
        int cycles;
        repeat (2) @(negedge clk_25MHz);
        buy      = do_buy;
        buy_kind = kind;
        upgrade  = do_up;
        fire_cmd = do_fire;
        @(negedge clk_25MHz);
        buy        = 1'b0;
        upgrade    = 1'b0;
        fire_cmd   = 1'b0;
        frame_tick = 1'b1;
        @(negedge clk_25MHz);
        frame_tick = 1'b0;
        wait_tick_done(cycles, seen);
        if (seen) begin
            model_tick(do_buy, kind, do_up, do_fire);
            compare_status(cycles);
        end
    endtask

    task automatic random_frame(output bit seen);
        rng = xorshift32(rng);
        run_frame(rng[4], unit_pkg::unit_kind_e'(rng[9:8]), rng[15:12] == 4'd0,
                  rng[21:20] == 2'd0, seen);
    endtask

    // a finished game must ignore frame_tick
    task automatic expect_no_tick();
        int n;
        @(negedge clk_25MHz);
        frame_tick = 1'b1;
        @(negedge clk_25MHz);
        frame_tick = 1'b0;
        n = 0;
        while (n < QUIET_CYCLES) begin
            @(negedge clk_25MHz);
            n++;
            if (tick_done) begin
                errors++;
                $display("tick_done came after the game had ended, at %0t ns", $time);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        frame_tick = 1'b0;
        buy        = 1'b0;
        buy_kind   = unit_pkg::killer_bird;
        upgrade    = 1'b0;
        fire_cmd   = 1'b0;
        rng        = 32'd72297;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        frames     = 0;
        ok         = 1'b1;
        repeat (4) @(posedge clk_25MHz);
        @(negedge clk_25MHz);
        rst   = 1'b0;
        start = 1'b1;
        @(negedge clk_25MHz);
        start = 1'b0;
        model_init();

        while (ok && !m_win && !m_lose && frames < MAX_FRAMES) begin
            random_frame(ok);
            frames++;
        end
        if (ok && !m_win && !m_lose) begin
            errors++;
            $display("game did not end within %0d frames", MAX_FRAMES);
        end

        if (ok) begin
            repeat (3) expect_no_tick();
            @(negedge clk_25MHz);
            start = 1'b1;
            @(negedge clk_25MHz);
            start = 1'b0;
            model_init();
            check_value("win after start", 32'(win), 32'd0);
            check_value("lose after start", 32'(lose), 32'd0);
            for (int f = 0; f < 3 && ok; f++)
                random_frame(ok);
        end

        $display("frames %0d, checks %0d, errors %0d, timeouts %0d",
                 frames, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
source/unit_pkg.sv
source/game_pkg.sv
source/command_latch.sv
source/tick_sequencer.sv
source/battle_field.sv
source/treasury.sv
source/status_report.sv
source/game_engine.sv
tb/clock_gen.sv
tb/tb_game_engine.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_game_engine
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
